// File: logic/calc_pkg.sv
package calc_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    localparam int DIGIT_W  = 4;
    localparam int VALUE_W  = 16;
    localparam int CURSOR_W = 2;

    // clk cycles between two sampling ticks, kept short for simulation
    localparam int TICK_DIV   = 16;
    localparam int TICK_CNT_W = $clog2(TICK_DIV);

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    typedef logic [DIGIT_W-1:0]         bcd_digit_t;
    // operand, -999 to 999
    typedef logic signed [VALUE_W-1:0]  value_t;
    // sum of two operands, -1998 to 1998
    typedef logic signed [VALUE_W-1:0]  sum_t;
    typedef logic [CURSOR_W-1:0]        cursor_t;
    typedef logic [TICK_CNT_W-1:0]      tick_cnt_t;

    // largest value a decimal digit can hold
    localparam bcd_digit_t DIGIT_MAX = bcd_digit_t'(9);

    // cursor positions
    localparam cursor_t CUR_ONES     = cursor_t'(0);
    localparam cursor_t CUR_TENS     = cursor_t'(1);
    localparam cursor_t CUR_HUNDREDS = cursor_t'(2);
    localparam cursor_t CUR_SIGN     = cursor_t'(3);

    // raw buttons and press pulses share this layout
    typedef struct packed {
        logic c;
        logic u;
        logic l;
        logic r;
        logic d;
    } button_set_t;

    // write into one operand slot, 0 is A and 1 is B
    typedef struct packed {
        logic   slot;
        value_t value;
    } operand_write_t;

endpackage

// File: logic/button_conditioner.sv
`timescale 1ns/10ps

module button_conditioner (
    input  logic                  clk,
    input  logic                  reset,
    input  calc_pkg::button_set_t buttons,
    output calc_pkg::button_set_t presses
);

    import calc_pkg::*;

    tick_cnt_t   tick_cnt;
    logic        tick;
    logic        tick_d;
    button_set_t samp1;
    button_set_t samp2;

    //////////////////////////////////////////////////////////////////////
    // sampling tick
    //////////////////////////////////////////////////////////////////////

    // tick is registered, so the first one lands TICK_DIV cycles after reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tick_cnt <= '0;
            tick     <= 1'b0;
        end else begin
            tick <= (tick_cnt == tick_cnt_t'(TICK_DIV - 1));
            if (tick_cnt == tick_cnt_t'(TICK_DIV - 1)) begin
                tick_cnt <= '0;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // two-stage sampling
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            samp1  <= '0;
            samp2  <= '0;
            tick_d <= 1'b0;
        end else begin
            // marks the cycle right after a shift
            tick_d <= tick;
            if (tick) begin
                samp1 <= buttons;
                samp2 <= samp1;
            end
        end
    end

    // rising edge between the two stages, seen for one cycle only
    always_comb begin
        if (tick_d) begin
            presses = button_set_t'(samp1 & ~samp2);
        end else begin
            presses = '0;
        end
    end

endmodule

// File: logic/digit_entry.sv
`timescale 1ns/10ps

module digit_entry (
    input  logic                     clk,
    input  logic                     reset,
    input  calc_pkg::button_set_t    presses,
    output calc_pkg::bcd_digit_t     ones,
    output calc_pkg::bcd_digit_t     tens,
    output calc_pkg::bcd_digit_t     hundreds,
    output logic                     sign,
    output calc_pkg::cursor_t        cursor,
    output logic                     slot,
    output logic                     wr,
    output calc_pkg::operand_write_t wr_data
);

    import calc_pkg::*;

    value_t magnitude;
    value_t entered;

    // one step up or down, held at the ends of the decimal range
    function automatic bcd_digit_t step_digit(input bcd_digit_t digit, input logic up);
        bcd_digit_t result;
        result = digit;
        if (up) begin
            if (digit != DIGIT_MAX) begin
                result = digit + 1'b1;
            end
        end else begin
            if (digit != '0) begin
                result = digit - 1'b1;
            end
        end
        return result;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // bcd to binary
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        magnitude = value_t'(hundreds) * 16'd100
                  + value_t'(tens) * 16'd10
                  + value_t'(ones);
        // no negative zero
        if (sign && (magnitude != '0)) begin
            entered = -magnitude;
        end else begin
            entered = magnitude;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // entry state
    //////////////////////////////////////////////////////////////////////

    // one press is served per cycle, c first, then l, r, u, d
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ones     <= '0;
            tens     <= '0;
            hundreds <= '0;
            sign     <= 1'b0;
            cursor   <= CUR_ONES;
            slot     <= 1'b0;
            wr       <= 1'b0;
            wr_data  <= '0;
        end else begin
            wr <= 1'b0;
            if (presses.c) begin
                // commit into the current slot, then start a fresh number
                wr            <= 1'b1;
                wr_data.slot  <= slot;
                wr_data.value <= entered;
                ones          <= '0;
                tens          <= '0;
                hundreds      <= '0;
                sign          <= 1'b0;
                cursor        <= CUR_ONES;
                slot          <= ~slot;
            end else if (presses.l) begin
                // wraps from sign back to ones
                cursor <= cursor + cursor_t'(1);
            end else if (presses.r) begin
                cursor <= cursor - cursor_t'(1);
            end else if (presses.u || presses.d) begin
                case (cursor)
                    CUR_ONES: begin
                        ones <= step_digit(ones, presses.u);
                    end
                    CUR_TENS: begin
                        tens <= step_digit(tens, presses.u);
                    end
                    CUR_HUNDREDS: begin
                        hundreds <= step_digit(hundreds, presses.u);
                    end
                    CUR_SIGN: begin
                        // up and down both flip the sign here
                        sign <= ~sign;
                    end
                endcase
            end
        end
    end

endmodule

// File: logic/operand_adder.sv
`timescale 1ns/10ps

module operand_adder (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wr,
    input  calc_pkg::operand_write_t wr_data,
    output calc_pkg::sum_t           sum,
    output logic                     sum_valid
);

    import calc_pkg::*;

    value_t operand_a;
    value_t operand_b;
    logic   a_written;
    logic   b_written;

    //////////////////////////////////////////////////////////////////////
    // operand slots
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            operand_a <= '0;
            operand_b <= '0;
            a_written <= 1'b0;
            b_written <= 1'b0;
        end else if (wr) begin
            if (wr_data.slot) begin
                operand_b <= wr_data.value;
                b_written <= 1'b1;
            end else begin
                operand_a <= wr_data.value;
                a_written <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // sum
    //////////////////////////////////////////////////////////////////////

    // follows the operands one cycle behind
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sum       <= '0;
            sum_valid <= 1'b0;
        end else begin
            sum       <= operand_a + operand_b;
            // once set, both flags stay set until reset
            sum_valid <= a_written & b_written;
        end
    end

endmodule

// File: logic/calc_entry_top.sv
`timescale 1ns/10ps

module calc_entry_top (
    input  logic                  clk,
    input  logic                  reset,
    input  calc_pkg::button_set_t buttons,
    output calc_pkg::bcd_digit_t  ones,
    output calc_pkg::bcd_digit_t  tens,
    output calc_pkg::bcd_digit_t  hundreds,
    output logic                  sign,
    output calc_pkg::cursor_t     cursor,
    output logic                  slot,
    output calc_pkg::sum_t        sum,
    output logic                  sum_valid
);

    import calc_pkg::*;

    button_set_t    presses;
    logic           wr;
    operand_write_t wr_data;

    // raw buttons to one-cycle press pulses
    button_conditioner cond0 (
        .clk     (clk),
        .reset   (reset),
        .buttons (buttons),
        .presses (presses)
    );

    // digit editing and operand commit
    digit_entry entry0 (
        .clk      (clk),
        .reset    (reset),
        .presses  (presses),
        .ones     (ones),
        .tens     (tens),
        .hundreds (hundreds),
        .sign     (sign),
        .cursor   (cursor),
        .slot     (slot),
        .wr       (wr),
        .wr_data  (wr_data)
    );

    operand_adder adder0 (
        .clk       (clk),
        .reset     (reset),
        .wr        (wr),
        .wr_data   (wr_data),
        .sum       (sum),
        .sum_valid (sum_valid)
    );

endmodule

// File: verif/calc_entry_chk.sv
`timescale 1ns/10ps

module calc_entry_chk (
    input logic                     clk,
    input logic                     reset,
    input calc_pkg::button_set_t    presses,
    input calc_pkg::bcd_digit_t     ones,
    input calc_pkg::bcd_digit_t     tens,
    input calc_pkg::bcd_digit_t     hundreds,
    input logic                     wr,
    input calc_pkg::operand_write_t wr_data,
    input calc_pkg::sum_t           sum,
    input logic                     sum_valid
);

    import calc_pkg::*;

    value_t ref_a;
    value_t ref_b;

    // operands as seen on the write strobe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ref_a <= '0;
            ref_b <= '0;
        end else if (wr) begin
            if (wr_data.slot) begin
                ref_b <= wr_data.value;
            end else begin
                ref_a <= wr_data.value;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // entry digits
    //////////////////////////////////////////////////////////////////////

    digit_range: assert property (@(posedge clk) disable iff (reset)
        (ones <= DIGIT_MAX) && (tens <= DIGIT_MAX) && (hundreds <= DIGIT_MAX))
        else $error("a digit left the decimal range");

    // the commit pulse clears the entry on its closing edge
    commit_clear: assert property (@(posedge clk) disable iff (reset)
        presses.c |=> (ones == '0) && (tens == '0) && (hundreds == '0))
        else $error("digits not cleared after a commit");

    //////////////////////////////////////////////////////////////////////
    // sum
    //////////////////////////////////////////////////////////////////////

    valid_sticky: assert property (@(posedge clk) disable iff (reset)
        sum_valid |=> sum_valid)
        else $error("sum_valid fell after rising");

    // sum lags the written operands by one cycle
    sum_match: assert property (@(posedge clk) disable iff (reset)
        sum_valid |-> (sum == $past(ref_a + ref_b)))
        else $error("sum differs from the written operands");

endmodule

bind calc_entry_top calc_entry_chk chk0 (
    .clk       (clk),
    .reset     (reset),
    .presses   (presses),
    .ones      (ones),
    .tens      (tens),
    .hundreds  (hundreds),
    .wr        (wr),
    .wr_data   (wr_data),
    .sum       (sum),
    .sum_valid (sum_valid)
);

// File: verif/calc_entry_tb.sv
`timescale 1ns/10ps

module calc_entry_tb;

    import calc_pkg::*;

    localparam int BTN_C = 0;
    localparam int BTN_U = 1;
    localparam int BTN_L = 2;
    localparam int BTN_R = 3;
    localparam int BTN_D = 4;
    localparam int HOLD = 3 * TICK_DIV;
    // upper bound on presses over all sequences, long holds included
    localparam int MAX_PRESSES = 200;

    logic        clk;
    logic        reset;
    button_set_t buttons;
    bcd_digit_t  ones;
    bcd_digit_t  tens;
    bcd_digit_t  hundreds;
    logic        sign;
    cursor_t     cursor;
    logic        slot;
    sum_t        sum;
    logic        sum_valid;

    integer seed = 32'h57b365cf;
    int     errors = 0;
    int     checks = 0;
    int     pos;
    int     operand;

    // reference model of the entry state and the operand slots
    int m_digit [3] = '{0, 0, 0};
    int m_sign = 0;
    int m_cursor = 0;
    int m_slot = 0;
    int op_a = 0;
    int op_b = 0;
    int a_done = 0;
    int b_done = 0;

    calc_entry_top dut0 (
        .clk       (clk),
        .reset     (reset),
        .buttons   (buttons),
        .ones      (ones),
        .tens      (tens),
        .hundreds  (hundreds),
        .sign      (sign),
        .cursor    (cursor),
        .slot      (slot),
        .sum       (sum),
        .sum_valid (sum_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // each press costs 6 tick periods, one extra period per press is slack
    initial begin
        repeat (MAX_PRESSES * 7 * TICK_DIV + 500) @(posedge clk);
        $display("timeout: the press sequences did not finish in time");
        $display("*** TEST FAILED ***");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // model and compare
    //////////////////////////////////////////////////////////////////////

    task automatic apply_model(input int btn);
        int value;
        value = m_digit[2] * 100 + m_digit[1] * 10 + m_digit[0];
        if (btn == BTN_C) begin
            if (m_sign != 0 && value != 0) begin
                value = -value;
            end
            if (m_slot == 0) begin
                op_a = value;
                a_done = 1;
            end else begin
                op_b = value;
                b_done = 1;
            end
            m_digit = '{0, 0, 0};
            m_sign = 0;
            m_cursor = 0;
            m_slot = 1 - m_slot;
        end else if (btn == BTN_L) begin
            m_cursor = (m_cursor + 1) % 4;
        end else if (btn == BTN_R) begin
            m_cursor = (m_cursor + 3) % 4;
        end else if (m_cursor == 3) begin
            m_sign = 1 - m_sign;
        end else if (btn == BTN_U && m_digit[m_cursor] < 9) begin
            m_digit[m_cursor]++;
        end else if (btn == BTN_D && m_digit[m_cursor] > 0) begin
            m_digit[m_cursor]--;
        end
    endtask

    task automatic check(input string name, input string what, input int exp, input int act);
        checks++;
        assert (exp == act) else begin
            $display("ERR %s %s expected %0d actual %0d", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic compare_all(input string name);
        check(name, "ones", m_digit[0], int'(ones));
        check(name, "tens", m_digit[1], int'(tens));
        check(name, "hundreds", m_digit[2], int'(hundreds));
        check(name, "sign", m_sign, int'(sign));
        check(name, "cursor", m_cursor, int'(cursor));
        check(name, "slot", m_slot, int'(slot));
        check(name, "sum_valid", a_done & b_done, int'(sum_valid));
        if (a_done != 0 && b_done != 0) begin
            check(name, "sum", op_a + op_b, int'(sum));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // button stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic press(input string name, input int btn, input int hold);
        @(posedge clk);
        #1;
        buttons.c = (btn == BTN_C);
        buttons.u = (btn == BTN_U);
        buttons.l = (btn == BTN_L);
        buttons.r = (btn == BTN_R);
        buttons.d = (btn == BTN_D);
        repeat (hold) @(posedge clk);
        #1 buttons = '0;
        repeat (HOLD) @(posedge clk);
        #1;
        apply_model(btn);
        compare_all(name);
    endtask

    // types a value in from a cleared entry and commits it
    task automatic enter_value(input string name, input int value);
        int mag;
        int p;
        int n;
        mag = (value < 0) ? -value : value;
        for (p = 0; p < 3; p++) begin
            for (n = 0; n < mag % 10; n++) begin
                press(name, BTN_U, HOLD);
            end
            mag = mag / 10;
            press(name, BTN_L, HOLD);
        end
        if (value < 0) begin
            press(name, BTN_U, HOLD);
        end
        press(name, BTN_C, HOLD);
    endtask

    //////////////////////////////////////////////////////////////////////
    // sequences
    //////////////////////////////////////////////////////////////////////

    initial begin
        buttons = '0;
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        compare_all("reset");
        check("reset", "sum", 0, int'(sum));
        // each digit runs into 9 and then back into 0
        for (pos = 0; pos < 3; pos++) begin
            repeat (10) press("digit_limits", BTN_U, HOLD);
            repeat (10) press("digit_limits", BTN_D, HOLD);
            press("digit_limits", BTN_L, HOLD);
        end
        press("cursor_wrap", BTN_L, HOLD);
        press("cursor_wrap", BTN_R, HOLD);
        press("sign_toggle", BTN_U, HOLD);
        press("sign_toggle", BTN_D, HOLD);
        press("sign_toggle", BTN_U, HOLD);
        press("cursor_wrap", BTN_L, HOLD);
        press("long_hold", BTN_U, 10 * TICK_DIV);
        press("commit", BTN_C, HOLD);
        press("commit", BTN_U, HOLD);
        press("commit", BTN_U, HOLD);
        press("commit", BTN_C, HOLD);
        // A, then B, then A again
        repeat (3) begin
            operand = {$random(seed)} % 1000;
            if ({$random(seed)} % 2 == 1) begin
                operand = -operand;
            end
            enter_value("random_sum", operand);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: build.f
logic/calc_pkg.sv
logic/button_conditioner.sv
logic/digit_entry.sv
logic/operand_adder.sv
logic/calc_entry_top.sv
verif/calc_entry_chk.sv
verif/calc_entry_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile with Verilator, run, and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module calc_entry_tb -f build.f \
    && ./obj_dir/Vcalc_entry_tb > sim.log 2>&1 \
    || echo "build or simulation error"
cat sim.log 2>/dev/null
grep -qF "*** TEST PASSED ***" sim.log 2>/dev/null && exit 0 || exit 1
